// File: hw/router_stream_pkg.sv
////////////////////////////////////////
// stream beat word shared by every valid/ready link in the router
// import wherever a beat or a beat-sized buffer is handled
////////////////////////////////////////

`default_nettype none

package router_stream_pkg;

    ////////////////////////////////////////
    // beat geometry

    localparam int beat_bytes       = 8;                     // bytes carried per beat
    localparam int beat_data_bits   = beat_bytes * 8;        // 64 bit data bus
    localparam int keep_cnt_bits    = $clog2(beat_bytes + 1); // holds 0..8 set keep bits

    ////////////////////////////////////////
    // packet limits

    localparam int max_packet_beats = 16;                    // also the lane buffer depth
    localparam int beat_idx_bits    = $clog2(max_packet_beats); // pointer / beat index width

    ////////////////////////////////////////
    // one beat on the wire

    typedef struct packed {
        logic [beat_data_bits-1:0] data;  // payload, byte 0 in the low bits
        logic [beat_bytes-1:0]     keep;  // one bit per valid byte
        logic                      last;  // closes the packet
    } stream_beat_t;                      // 73 bits

endpackage

`default_nettype wire

// File: hw/router_meta_pkg.sv
////////////////////////////////////////
// port count and side-band metadata words for ingress, lanes and egress
////////////////////////////////////////

`default_nettype none

package router_meta_pkg;

    localparam int num_ports     = 4;  // lanes == physical ports
    localparam int port_id_bits  = 2;  // enough for num_ports
    localparam int byte_len_bits = 8;  // up to 128 bytes per packet

    // side-band on the router input, valid on the first beat
    typedef struct packed {
        logic [port_id_bits-1:0] ingress_port;
    } ingress_metadata_t;

    // match-action view inside a lane
    typedef struct packed {
        logic [port_id_bits-1:0]  ing_port;     // where it came in
        logic [port_id_bits-1:0]  egr_spec;     // where the rule sends it
        logic [byte_len_bits-1:0] byte_length;  // whole packet, in bytes
    } user_metadata_t;

    // side-band on the router output, held for every beat
    typedef struct packed {
        logic [port_id_bits-1:0]  ingress_port;
        logic [port_id_bits-1:0]  egress_port;
        logic [byte_len_bits-1:0] byte_length;
    } wrapper_metadata_t;

endpackage

`default_nettype wire

// File: hw/ingress_steer.sv
////////////////////////////////////////
// sends each whole input packet to the lane of its ingress port
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ingress_steer (
    input  logic                                        packet_data_in, // clock
    input  logic                                        reset,
    input  router_stream_pkg::stream_beat_t             in_beat,
    input  router_meta_pkg::ingress_metadata_t          in_meta,
    input  logic                                        in_valid,
    output logic                                        in_ready,
    output router_stream_pkg::stream_beat_t             lane_beat,
    output router_meta_pkg::ingress_metadata_t          lane_meta,
    output logic [router_meta_pkg::num_ports-1:0]       lane_valid,
    input  logic [router_meta_pkg::num_ports-1:0]       lane_ready
);

    import router_meta_pkg::*;

    logic                       ready_en;   // low for one cycle out of reset
    logic                       in_pkt;     // between first and last beat
    logic [port_id_bits-1:0]    sel_q;      // lane held for the packet
    logic [port_id_bits-1:0]    sel;        // lane for the current beat
    logic                       in_fire;

    ////////////////////////////////////////
    // lane selection

    assign sel       = in_pkt ? sel_q : in_meta.ingress_port; // first beat picks, rest follow
    assign in_fire   = in_valid && in_ready;
    assign in_ready  = ready_en && lane_ready[sel];           // chosen lane backpressures us
    assign lane_beat = in_beat;                               // same beat to all lanes
    assign lane_meta.ingress_port = sel;                      // stable for the whole packet

    always_comb begin
        lane_valid = '0;
        if (ready_en) begin
            lane_valid[sel] = in_valid;  // only the selected lane sees valid
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (reset) begin
            ready_en <= 1'b0;
            in_pkt   <= 1'b0;
            sel_q    <= '0;
        end else begin
            ready_en <= 1'b1;
            if (in_fire) begin
                if (in_beat.last) begin
                    in_pkt <= 1'b0;    // next beat starts a new packet
                end else if (!in_pkt) begin
                    in_pkt <= 1'b1;
                    sel_q  <= sel;     // lock on the first beat
                end
            end
        end
    end

    ////////////////////////////////////////
    // checks

    // a packet never splits across lanes
    a_lane_stable : assert property (@(posedge packet_data_in) disable iff (reset)
        in_fire && !in_beat.last |=> lane_meta.ingress_port == $past(lane_meta.ingress_port))
        else $error("ingress lane changed inside a packet");

endmodule

`default_nettype wire

// File: hw/echo_port_lane.sv
////////////////////////////////////////
// one port lane: byte count, echo rule, store-and-forward packet buffer
// one packet reads out while the next one fills
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module echo_port_lane (
    input  logic                                packet_data_in, // clock
    input  logic                                reset,
    input  router_stream_pkg::stream_beat_t     in_beat,
    input  router_meta_pkg::ingress_metadata_t  in_meta,
    input  logic                                in_valid,
    output logic                                in_ready,
    output router_stream_pkg::stream_beat_t     out_beat,
    output router_meta_pkg::wrapper_metadata_t  out_meta,
    output logic                                out_valid,
    input  logic                                out_ready
);

    import router_stream_pkg::*;
    import router_meta_pkg::*;

    stream_beat_t               mem [max_packet_beats];  // packet store
    logic [beat_idx_bits-1:0]   wr_ptr;
    logic [beat_idx_bits-1:0]   rd_ptr;
    logic [beat_idx_bits:0]     count;          // beats held, 0..16
    logic [beat_idx_bits-1:0]   beat_cnt;       // beats accepted in this packet
    logic [port_id_bits-1:0]    ing_port_q;     // from the first beat
    logic [keep_cnt_bits-1:0]   last_keep_bytes;
    logic [byte_len_bits-1:0]   byte_len;
    user_metadata_t             um_in;          // into the match-action step
    user_metadata_t             um_out;         // after the echo rule
    user_metadata_t             um_done;        // finished packet, not yet released
    wrapper_metadata_t          rd_meta;        // packet being read out
    logic                       done_pend;      // finished packet waiting
    logic                       rd_active;      // read-out in progress
    logic                       full;
    logic                       in_fire;
    logic                       rd_en;

    ////////////////////////////////////////
    // byte length

    always_comb begin
        last_keep_bytes = '0;
        for (int i = 0; i < beat_bytes; i++) begin
            last_keep_bytes += keep_cnt_bits'(in_beat.keep[i]);  // popcount
        end
    end

    // full beats so far plus the bytes of the last one
    assign byte_len = byte_len_bits'(beat_cnt) * byte_len_bits'(beat_bytes)
                    + byte_len_bits'(last_keep_bytes);

    ////////////////////////////////////////
    // echo match-action

    assign um_in.ing_port    = (beat_cnt == '0) ? in_meta.ingress_port : ing_port_q;
    assign um_in.egr_spec    = '0;        // filled by the rule
    assign um_in.byte_length = byte_len;

    always_comb begin
        um_out          = um_in;
        um_out.egr_spec = um_in.ing_port;  // echo: send back out the way it came
    end

    ////////////////////////////////////////
    // handshake

    assign full      = (count == (beat_idx_bits + 1)'(max_packet_beats));
    assign in_ready  = !full && !done_pend;   // hold off while a packet waits
    assign in_fire   = in_valid && in_ready;
    assign out_valid = rd_active;             // whole packet is present
    assign rd_en     = out_valid && out_ready;
    assign out_beat  = mem[rd_ptr];
    assign out_meta  = rd_meta;

    always_ff @(posedge packet_data_in) begin
        if (in_fire) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            beat_cnt  <= '0;
            done_pend <= 1'b0;
            rd_active <= 1'b0;
        end else begin
            if (in_fire) begin
                wr_ptr   <= wr_ptr + 1'b1;
                beat_cnt <= in_beat.last ? '0 : beat_cnt + 1'b1;
                if (in_beat.last) begin
                    done_pend <= 1'b1;       // length known, release next cycle
                end
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (out_beat.last) begin
                    rd_active <= 1'b0;
                end
            end
            if (done_pend && !rd_active) begin
                rd_active <= 1'b1;           // readable from the next cycle
                done_pend <= 1'b0;
            end
            case ({in_fire, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // metadata words travel with the packet
    always_ff @(posedge packet_data_in) begin
        if (in_fire && beat_cnt == '0) begin
            ing_port_q <= in_meta.ingress_port;
        end
        if (in_fire && in_beat.last) begin
            um_done <= um_out;
        end
        if (done_pend && !rd_active) begin
            rd_meta.ingress_port <= um_done.ing_port;
            rd_meta.egress_port  <= um_done.egr_spec;
            rd_meta.byte_length  <= um_done.byte_length;
        end
    end

    ////////////////////////////////////////
    // checks

    a_no_write_full : assert property (@(posedge packet_data_in) disable iff (reset)
        in_fire |-> count < (beat_idx_bits + 1)'(max_packet_beats))
        else $error("lane write into a full buffer");

    a_no_read_empty : assert property (@(posedge packet_data_in) disable iff (reset)
        rd_en |-> count != '0)
        else $error("lane read with nothing buffered");

endmodule

`default_nettype wire

// File: hw/egress_arbiter.sv
////////////////////////////////////////
// round-robin merge of lane packets onto one registered output
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module egress_arbiter (
    input  logic                                    packet_data_in, // clock
    input  logic                                    reset,
    input  router_stream_pkg::stream_beat_t         lane_beat [router_meta_pkg::num_ports],
    input  router_meta_pkg::wrapper_metadata_t      lane_meta [router_meta_pkg::num_ports],
    input  logic [router_meta_pkg::num_ports-1:0]   lane_valid,
    output logic [router_meta_pkg::num_ports-1:0]   lane_ready,
    output router_stream_pkg::stream_beat_t         out_beat,
    output router_meta_pkg::wrapper_metadata_t      out_meta,
    output logic                                    out_valid,
    input  logic                                    out_ready
);

    import router_meta_pkg::*;

    logic                       locked;     // mid-packet, grant frozen
    logic [port_id_bits-1:0]    lock_idx;
    logic [port_id_bits-1:0]    rr_ptr;     // highest priority lane
    logic [port_id_bits-1:0]    pick_idx;
    logic                       pick_valid;
    logic [port_id_bits-1:0]    cur_idx;
    logic                       load_en;    // output register can take a beat
    logic                       take;

    ////////////////////////////////////////
    // round-robin pick

    always_comb begin : rr_pick
        logic [port_id_bits-1:0] idx;
        pick_idx   = rr_ptr;
        pick_valid = 1'b0;
        idx        = rr_ptr;
        for (int k = num_ports - 1; k >= 0; k--) begin  // nearest to rr_ptr wins
            idx = rr_ptr + port_id_bits'(k);
            if (lane_valid[idx]) begin
                pick_idx   = idx;
                pick_valid = 1'b1;
            end
        end
    end

    assign cur_idx = locked ? lock_idx : pick_idx;
    assign load_en = !out_valid || out_ready;

    always_comb begin
        lane_ready = '0;
        if (load_en && (locked || pick_valid)) begin
            lane_ready[cur_idx] = 1'b1;   // one lane at a time
        end
    end

    assign take = lane_valid[cur_idx] && lane_ready[cur_idx];

    ////////////////////////////////////////
    // grant lock and output register

    always_ff @(posedge packet_data_in) begin
        if (reset) begin
            locked    <= 1'b0;
            lock_idx  <= '0;
            rr_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (take) begin
                if (lane_beat[cur_idx].last) begin
                    locked <= 1'b0;
                    rr_ptr <= cur_idx + 1'b1;  // move past the lane just served
                end else begin
                    locked   <= 1'b1;
                    lock_idx <= cur_idx;
                end
            end
            if (load_en) begin
                out_valid <= take;
            end
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (load_en && take) begin
            out_beat <= lane_beat[cur_idx];
            out_meta <= lane_meta[cur_idx];
        end
    end

    ////////////////////////////////////////
    // checks

    a_ready_onehot : assert property (@(posedge packet_data_in) disable iff (reset)
        $onehot0(lane_ready))
        else $error("more than one lane granted");

    // a lane holds valid for its whole packet once it has started
    a_locked_valid : assert property (@(posedge packet_data_in) disable iff (reset)
        locked |-> lane_valid[lock_idx])
        else $error("locked lane dropped valid mid-packet");

endmodule

`default_nettype wire

// File: hw/echo_router_top.sv
////////////////////////////////////////
// echo router slice: steer, four port lanes, egress arbiter
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module echo_router_top (
    input  logic                                packet_data_in, // clock
    input  logic                                reset,
    input  router_stream_pkg::stream_beat_t     in_beat,
    input  router_meta_pkg::ingress_metadata_t  in_meta,
    input  logic                                in_valid,
    output logic                                in_ready,
    output router_stream_pkg::stream_beat_t     out_beat,
    output router_meta_pkg::wrapper_metadata_t  out_meta,
    output logic                                out_valid,
    input  logic                                out_ready
);

    import router_stream_pkg::*;
    import router_meta_pkg::*;

    stream_beat_t           steer_beat;                 // fanned out to all lanes
    ingress_metadata_t      steer_meta;
    logic [num_ports-1:0]   steer_valid;
    logic [num_ports-1:0]   steer_ready;

    stream_beat_t           lane_out_beat [num_ports];
    wrapper_metadata_t      lane_out_meta [num_ports];
    logic [num_ports-1:0]   lane_out_valid;
    logic [num_ports-1:0]   grant_ready;

    ingress_steer i_ingress_steer (
        .packet_data_in (packet_data_in),
        .reset          (reset),
        .in_beat        (in_beat),
        .in_meta        (in_meta),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .lane_beat      (steer_beat),
        .lane_meta      (steer_meta),
        .lane_valid     (steer_valid),
        .lane_ready     (steer_ready)
    );

    for (genvar i = 0; i < num_ports; i++) begin : g_lane
        echo_port_lane i_echo_port_lane (
            .packet_data_in (packet_data_in),
            .reset          (reset),
            .in_beat        (steer_beat),
            .in_meta        (steer_meta),
            .in_valid       (steer_valid[i]),
            .in_ready       (steer_ready[i]),
            .out_beat       (lane_out_beat[i]),
            .out_meta       (lane_out_meta[i]),
            .out_valid      (lane_out_valid[i]),
            .out_ready      (grant_ready[i])
        );
    end

    egress_arbiter i_egress_arbiter (
        .packet_data_in (packet_data_in),
        .reset          (reset),
        .lane_beat      (lane_out_beat),
        .lane_meta      (lane_out_meta),
        .lane_valid     (lane_out_valid),
        .lane_ready     (grant_ready),
        .out_beat       (out_beat),
        .out_meta       (out_meta),
        .out_valid      (out_valid),
        .out_ready      (out_ready)
    );

endmodule

`default_nettype wire

// File: tests/echo_router_tb.sv
////////////////////////////////////////
// testbench for the echo router: seeded random packets on all ports,
// per-port reference queues, checks on every output beat
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module echo_router_tb;

    import router_stream_pkg::*;
    import router_meta_pkg::*;

    localparam int num_packets = 200;
    localparam int cycle_limit = num_packets * max_packet_beats * 4;  // generous for stalls

    // one expected packet in the model
    typedef struct packed {
        stream_beat_t [max_packet_beats-1:0] beats;
        logic [beat_idx_bits:0]              nbeats;  // 1..16
        wrapper_metadata_t                   meta;
    } pkt_t;

    logic               packet_data_in = 1'b0;  // clock
    logic               reset;
    stream_beat_t       in_beat;
    ingress_metadata_t  in_meta;
    logic               in_valid;
    logic               in_ready;
    stream_beat_t       out_beat;
    wrapper_metadata_t  out_meta;
    logic               out_valid;
    logic               out_ready = 1'b0;

    pkt_t                       exp_q [num_ports][$];  // model, one queue per ingress port
    int                         value_errors  = 0;
    int                         flow_errors   = 0;
    int                         beats_checked = 0;
    int                         total_beats   = 0;
    int                         cycle_cnt     = 0;
    int                         since_reset   = 0;     // monitor cycles after reset release
    logic                       in_fire_seen  = 1'b0;  // input beat moves on next edge
    logic                       first_pkt_in  = 1'b0;  // some lane has a whole packet
    logic                       out_mid       = 1'b0;  // inside an output packet
    logic [port_id_bits-1:0]    out_port      = '0;
    logic [byte_len_bits-1:0]   out_len       = '0;
    logic [beat_idx_bits:0]     out_idx       = '0;   // beat position in the head packet

    echo_router_top i_echo_router_top (
        .packet_data_in (packet_data_in),
        .reset          (reset),
        .in_beat        (in_beat),
        .in_meta        (in_meta),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_beat       (out_beat),
        .out_meta       (out_meta),
        .out_valid      (out_valid),
        .out_ready      (out_ready)
    );

    always #2 packet_data_in = ~packet_data_in;  // 4 ns period

    ////////////////////////////////////////
    // reporting helpers

    task automatic report_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        value_errors++;
    endtask

    task automatic report_flow(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        flow_errors++;
    endtask

    task automatic print_counts();
        $display("value errors: %0d, flow errors: %0d, beats checked: %0d of %0d",
                 value_errors, flow_errors, beats_checked, total_beats);
    endtask

    ////////////////////////////////////////
    // stimulus and model

    function automatic pkt_t make_packet();
        pkt_t                    pkt;
        int                      nb;
        int                      keep_bits;
        logic [port_id_bits-1:0] port;
        pkt       = '0;
        port      = port_id_bits'($urandom % num_ports);
        nb        = 1 + int'($urandom % max_packet_beats);
        keep_bits = 1 + int'($urandom % beat_bytes);   // contiguous low bytes
        for (int b = 0; b < nb; b++) begin
            pkt.beats[beat_idx_bits'(b)].data = {$urandom, $urandom};
            pkt.beats[beat_idx_bits'(b)].keep = '1;    // full beats before the last
            pkt.beats[beat_idx_bits'(b)].last = 1'b0;
        end
        pkt.beats[beat_idx_bits'(nb - 1)].keep = 8'hff >> (beat_bytes - keep_bits);
        pkt.beats[beat_idx_bits'(nb - 1)].last = 1'b1;
        pkt.nbeats           = (beat_idx_bits + 1)'(nb);
        pkt.meta.ingress_port = port;
        pkt.meta.egress_port  = port;                  // echo rule
        pkt.meta.byte_length  = byte_len_bits'(nb * beat_bytes - beat_bytes + keep_bits);
        return pkt;
    endfunction

    function automatic bit all_drained();
        bit empty;
        empty = !out_mid;
        for (int p = 0; p < num_ports; p++) begin
            if (exp_q[p].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    always @(posedge packet_data_in) begin : drive_out_ready
        if (reset) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= ($urandom % 4 != 0);  // stall about one cycle in four
        end
    end

    initial begin : drive_input
        pkt_t pkt;
        void'($urandom(32'h6184_b6d7));
        reset    = 1'b1;
        in_beat  = '0;
        in_meta  = '0;
        in_valid = 1'b0;
        repeat (4) @(posedge packet_data_in);
        reset <= 1'b0;
        for (int p = 0; p < num_packets; p++) begin
            pkt = make_packet();
            exp_q[pkt.meta.ingress_port].push_back(pkt);
            total_beats += int'(pkt.nbeats);
            for (int b = 0; b < int'(pkt.nbeats); b++) begin
                while ($urandom % 4 == 0) begin     // random idle gap
                    in_valid <= 1'b0;
                    @(posedge packet_data_in);
                end
                in_beat  <= pkt.beats[beat_idx_bits'(b)];
                // later beats carry junk meta, the steer must hold its lane
                in_meta.ingress_port <= (b == 0) ? pkt.meta.ingress_port
                                                 : port_id_bits'($urandom);
                in_valid <= 1'b1;
                @(posedge packet_data_in);
                while (!in_fire_seen) begin         // hold until accepted
                    @(posedge packet_data_in);
                end
            end
        end
        in_valid <= 1'b0;
        while (!all_drained()) begin
            @(posedge packet_data_in);
        end
        repeat (20) @(posedge packet_data_in);      // catch stray or repeated beats
        if (out_valid) begin
            report_flow("output still valid after every packet was delivered");
        end
        if (beats_checked != total_beats) begin
            report_value("output beat count", 64'(total_beats), 64'(beats_checked));
        end
        print_counts();
        if (value_errors + flow_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    ////////////////////////////////////////
    // output monitor, sampled mid-cycle

    always @(negedge packet_data_in) begin : monitor
        pkt_t                    exp;
        stream_beat_t            exp_beat;
        logic [port_id_bits-1:0] port;
        in_fire_seen = in_valid && in_ready;
        if (!reset) begin
            since_reset++;
            if (since_reset == 1 && in_ready) begin      // held off for one cycle
                report_value("in_ready", 64'(1'b0), 64'(in_ready));
            end
            if (since_reset == 2 && !in_ready) begin     // all lanes empty by now
                report_value("in_ready", 64'(1'b1), 64'(in_ready));
            end
            if (out_valid && !first_pkt_in) begin
                report_flow("out_valid rose before any lane held a whole packet");
            end
            if (in_fire_seen && in_beat.last) begin
                first_pkt_in = 1'b1;
            end
            if (out_valid && out_ready) begin
                port = out_meta.ingress_port;
                if (out_mid && port != out_port) begin    // interleaved packets
                    report_value("out_meta.ingress_port", 64'(out_port), 64'(port));
                end
                if (out_mid && out_meta.byte_length != out_len) begin
                    report_value("out_meta.byte_length", 64'(out_len),
                                 64'(out_meta.byte_length));
                end
                if (exp_q[port].size() == 0) begin
                    report_flow($sformatf("beat for port %0d with no packet expected", port));
                end else begin
                    exp      = exp_q[port][0];
                    exp_beat = exp.beats[out_idx[beat_idx_bits-1:0]];
                    if (out_beat.data != exp_beat.data) begin
                        report_value("out_beat.data", exp_beat.data, out_beat.data);
                    end
                    if (out_beat.keep != exp_beat.keep) begin
                        report_value("out_beat.keep", 64'(exp_beat.keep), 64'(out_beat.keep));
                    end
                    if (out_beat.last != exp_beat.last) begin
                        report_value("out_beat.last", 64'(exp_beat.last), 64'(out_beat.last));
                    end
                    if (out_meta.egress_port != exp.meta.egress_port) begin
                        report_value("out_meta.egress_port", 64'(exp.meta.egress_port),
                                     64'(out_meta.egress_port));
                    end
                    if (!out_mid && out_meta.byte_length != exp.meta.byte_length) begin
                        report_value("out_meta.byte_length", 64'(exp.meta.byte_length),
                                     64'(out_meta.byte_length));
                    end
                    beats_checked++;
                    out_idx = out_idx + 1'b1;
                    if (out_idx == exp.nbeats) begin      // packet done in the model
                        void'(exp_q[port].pop_front());
                        out_idx = '0;
                    end
                end
                out_mid  = !out_beat.last;
                out_port = port;
                out_len  = out_meta.byte_length;
            end
        end
    end

    always @(posedge packet_data_in) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run passed %0d cycles with packets still outstanding",
                     cycle_limit);
            print_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
hw/router_stream_pkg.sv
hw/router_meta_pkg.sv
hw/ingress_steer.sv
hw/echo_port_lane.sv
hw/egress_arbiter.sv
hw/echo_router_top.sv
tests/echo_router_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := echo_router_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended without a verdict"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
